//--- common/rotate_pkg.sv
`default_nettype none

package rotate_pkg;

   // frame geometry, largest frame is 16x16
   // dims need one extra bit so a count of 16 fits
   localparam int DIM_WIDTH    = 5;
   localparam int MAX_COLS     = 16;
   localparam int MAX_ROWS     = 16;
   localparam int DEFAULT_COLS = 16;
   localparam int DEFAULT_ROWS = 16;

   // one bank of the double buffer
   localparam int ADDR_WIDTH = 8;
   localparam int BANK_WORDS = MAX_COLS * MAX_ROWS;

   localparam int DATA_WIDTH = 16;

   // signed sin/cos, 8 fraction bits so 256 is 1.0
   localparam int ANGLE_WIDTH = 10;
   localparam int ANGLE_FRAC  = 8;
   localparam int ANGLE_ONE   = 1 << ANGLE_FRAC;

   // rotate datapath: centered coord is DIM_WIDTH+1 signed, times the angle,
   // plus one bit for the sum of two products
   localparam int PROD_WIDTH = DIM_WIDTH + ANGLE_WIDTH + 2;
   // what is left once the fraction is dropped
   localparam int ROT_WIDTH  = PROD_WIDTH - ANGLE_FRAC;

   // apb register map
   localparam int APB_ADDR_WIDTH = 4;
   localparam int APB_DATA_WIDTH = 32;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 4'h0;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_SIN    = 4'h4;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_COS    = 4'h8;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 4'hC;

   // status word field positions
   localparam int STAT_COLS_LSB = 0;
   localparam int STAT_ROWS_LSB = 8;
   localparam int STAT_BANK_BIT = 16;

   // token types, any other code passes through untouched
   typedef enum logic [2:0] {
      FRAME_START = 3'd1,
      ROW_START   = 3'd2,
      PIXEL       = 3'd3,
      ROW_END     = 3'd4,
      FRAME_END   = 3'd5
   } stream_dtype_e;

   typedef struct packed {
      stream_dtype_e         dtype;
      logic [DATA_WIDTH-1:0] data;
   } stream_token_t;

endpackage

`default_nettype wire

//--- common/decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decode_if;
   import rotate_pkg::*;

   // token as presented one cycle earlier
   logic                          valid;
   stream_token_t                 token;
   // position of this token inside the frame
   logic [DIM_WIDTH-1:0]          row;
   logic [DIM_WIDTH-1:0]          col;
   // size learned from the previous frame
   logic [DIM_WIDTH-1:0]          num_rows;
   logic [DIM_WIDTH-1:0]          num_cols;
   // angle latched at frame start
   logic signed [ANGLE_WIDTH-1:0] sin_theta;
   logic signed [ANGLE_WIDTH-1:0] cos_theta;
   // write side of the double buffer
   logic                          bank;
   logic [ADDR_WIDTH-1:0]         wr_addr;
   logic                          wr_en;
   logic                          enable;

   modport src (output valid, token, row, col, num_rows, num_cols,
                output sin_theta, cos_theta, bank, wr_addr, wr_en, enable);
   modport dst (input valid, token, row, col, num_rows, num_cols,
                input sin_theta, cos_theta, bank, wr_addr, wr_en, enable);

endinterface

`default_nettype wire

//--- common/fetch_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_if;
   import rotate_pkg::*;

   // token two cycles after entry
   logic                  valid;
   stream_token_t         token;
   // write port, bank is the one being filled
   logic                  bank;
   logic [ADDR_WIDTH-1:0] wr_addr;
   logic                  wr_en;
   // read port, always the other bank
   logic [ADDR_WIDTH-1:0] raddr;
   // rotated source fell outside the image
   logic                  out_of_bounds;
   logic                  enable;

   modport src (output valid, token, bank, wr_addr, wr_en,
                output raddr, out_of_bounds, enable);
   modport dst (input valid, token, bank, wr_addr, wr_en,
                input raddr, out_of_bounds, enable);

endinterface

`default_nettype wire

//--- hdl/rotate_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module rotate_apb_regs (
   input  logic                                       clk,
   input  logic                                       resetb,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [rotate_pkg::APB_ADDR_WIDTH-1:0]      paddr,
   input  logic [rotate_pkg::APB_DATA_WIDTH-1:0]      pwdata,
   output logic [rotate_pkg::APB_DATA_WIDTH-1:0]      prdata,
   output logic                                       pready,
   output logic                                       pslverr,
   output logic                                       enable,
   output logic signed [rotate_pkg::ANGLE_WIDTH-1:0]  sin_theta,
   output logic signed [rotate_pkg::ANGLE_WIDTH-1:0]  cos_theta,
   input  logic [rotate_pkg::DIM_WIDTH-1:0]           num_cols,
   input  logic [rotate_pkg::DIM_WIDTH-1:0]           num_rows,
   input  logic                                       bank
);
   import rotate_pkg::*;

   logic                      access;
   logic                      mapped;
   logic [APB_DATA_WIDTH-1:0] status_word;

   // access phase of a transfer
   assign access = psel && penable;
   assign mapped = paddr inside {REG_CTRL, REG_SIN, REG_COS, REG_STATUS};

   // no wait states
   assign pready = 1'b1;
   // status is read only
   assign pslverr = access && (!mapped || (pwrite && paddr == REG_STATUS));

   // writes land on the access edge
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         enable    <= 1'b0;
         sin_theta <= '0;
         cos_theta <= ANGLE_WIDTH'(ANGLE_ONE);
      end else if (access && pwrite) begin
         case (paddr)
            REG_CTRL: enable    <= pwdata[0];
            REG_SIN:  sin_theta <= pwdata[ANGLE_WIDTH-1:0];
            REG_COS:  cos_theta <= pwdata[ANGLE_WIDTH-1:0];
            default:  ;
         endcase
      end
   end

   // learned size and the bank being written
   always_comb begin
      status_word = '0;
      status_word[STAT_COLS_LSB +: DIM_WIDTH] = num_cols;
      status_word[STAT_ROWS_LSB +: DIM_WIDTH] = num_rows;
      status_word[STAT_BANK_BIT] = bank;
   end

   // read mux, angles come back sign extended
   always_comb begin
      case (paddr)
         REG_CTRL:   prdata = {{(APB_DATA_WIDTH-1){1'b0}}, enable};
         REG_SIN:    prdata = {{(APB_DATA_WIDTH-ANGLE_WIDTH){sin_theta[ANGLE_WIDTH-1]}}, sin_theta};
         REG_COS:    prdata = {{(APB_DATA_WIDTH-ANGLE_WIDTH){cos_theta[ANGLE_WIDTH-1]}}, cos_theta};
         REG_STATUS: prdata = status_word;
         default:    prdata = '0;
      endcase
   end

   // an access phase always follows a setup phase
   assert property (@(posedge clk) disable iff (!resetb)
      penable |-> (psel && $past(psel)));

endmodule

`default_nettype wire

//--- rotator/stream_decode.sv
`timescale 1ns/100ps
`default_nettype none

module stream_decode (
   input  logic                                      clk,
   input  logic                                      resetb,
   input  logic                                      in_valid,
   input  rotate_pkg::stream_dtype_e                 in_dtype,
   input  logic [rotate_pkg::DATA_WIDTH-1:0]         in_data,
   input  logic                                      enable,
   input  logic signed [rotate_pkg::ANGLE_WIDTH-1:0] sin_theta,
   input  logic signed [rotate_pkg::ANGLE_WIDTH-1:0] cos_theta,
   output logic [rotate_pkg::DIM_WIDTH-1:0]          num_cols,
   output logic [rotate_pkg::DIM_WIDTH-1:0]          num_rows,
   output logic                                      bank,
   decode_if.src                                     dec
);
   import rotate_pkg::*;

   logic [DIM_WIDTH-1:0]          row_cnt;
   logic [DIM_WIDTH-1:0]          col_cnt;
   logic [ADDR_WIDTH-1:0]         wr_ptr;
   logic signed [ANGLE_WIDTH-1:0] sin_q;
   logic signed [ANGLE_WIDTH-1:0] cos_q;
   logic                          active;
   logic                          is_pixel;

   // everything freezes while disabled
   assign active   = in_valid && enable;
   assign is_pixel = active && (in_dtype == PIXEL);

   // frame tracking
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_cnt  <= '0;
         col_cnt  <= '0;
         wr_ptr   <= '0;
         num_cols <= DIM_WIDTH'(DEFAULT_COLS);
         num_rows <= DIM_WIDTH'(DEFAULT_ROWS);
         bank     <= 1'b0;
         sin_q    <= '0;
         cos_q    <= ANGLE_WIDTH'(ANGLE_ONE);
      end else if (active) begin
         case (in_dtype)
            FRAME_START: begin
               // swap banks and take the new angle for the whole frame
               row_cnt <= '0;
               col_cnt <= '0;
               wr_ptr  <= '0;
               bank    <= !bank;
               sin_q   <= sin_theta;
               cos_q   <= cos_theta;
            end
            ROW_START: col_cnt <= '0;
            PIXEL: begin
               col_cnt <= col_cnt + 1'b1;
               wr_ptr  <= wr_ptr + 1'b1;
            end
            ROW_END: begin
               // width of the row just finished
               row_cnt  <= row_cnt + 1'b1;
               num_cols <= col_cnt;
            end
            FRAME_END: num_rows <= row_cnt;
            default: ;
         endcase
      end
   end

   // stage register, position is the one before this token's update
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dec.valid   <= 1'b0;
         dec.token   <= '0;
         dec.row     <= '0;
         dec.col     <= '0;
         dec.wr_addr <= '0;
         dec.wr_en   <= 1'b0;
         dec.enable  <= 1'b0;
      end else begin
         dec.valid   <= in_valid;
         dec.token   <= '{dtype: in_dtype, data: in_data};
         dec.row     <= row_cnt;
         dec.col     <= col_cnt;
         dec.wr_addr <= wr_ptr;
         dec.wr_en   <= is_pixel;
         dec.enable  <= enable;
      end
   end

   // these only change on the edge that moves the token on
   assign dec.num_cols  = num_cols;
   assign dec.num_rows  = num_rows;
   assign dec.sin_theta = sin_q;
   assign dec.cos_theta = cos_q;
   assign dec.bank      = bank;

   // stream must respect the max frame width
   assert property (@(posedge clk) disable iff (!resetb)
      is_pixel |-> (col_cnt < DIM_WIDTH'(MAX_COLS)));

endmodule

`default_nettype wire

//--- rotator/coord_rotate.sv
`timescale 1ns/100ps
`default_nettype none

module coord_rotate (
   input  logic  clk,
   input  logic  resetb,
   decode_if.dst dec,
   fetch_if.src  fet
);
   import rotate_pkg::*;

   logic [DIM_WIDTH-1:0]         half_cols;
   logic [DIM_WIDTH-1:0]         half_rows;
   logic signed [DIM_WIDTH:0]    col_c;
   logic signed [DIM_WIDTH:0]    row_c;
   logic signed [PROD_WIDTH-1:0] col_prod;
   logic signed [PROD_WIDTH-1:0] row_prod;
   logic signed [PROD_WIDTH-1:0] col_shift;
   logic signed [PROD_WIDTH-1:0] row_shift;
   logic signed [ROT_WIDTH-1:0]  col_rot;
   logic signed [ROT_WIDTH-1:0]  row_rot;
   logic signed [ROT_WIDTH-1:0]  col_src;
   logic signed [ROT_WIDTH-1:0]  row_src;
   logic                         oob;
   logic [2*DIM_WIDTH:0]         raddr_full;

   assign half_cols = dec.num_cols >> 1;
   assign half_rows = dec.num_rows >> 1;

   // move origin to the image center
   assign col_c = $signed({1'b0, dec.col}) - $signed({1'b0, half_cols});
   assign row_c = $signed({1'b0, dec.row}) - $signed({1'b0, half_rows});

   // rotation matrix
   assign col_prod = (col_c * dec.cos_theta) - (row_c * dec.sin_theta);
   assign row_prod = (col_c * dec.sin_theta) + (row_c * dec.cos_theta);

   // drop fraction bits, arithmetic shift floors toward -inf
   assign col_shift = col_prod >>> ANGLE_FRAC;
   assign row_shift = row_prod >>> ANGLE_FRAC;

   // origin back to top left
   assign col_rot = $signed(col_shift[ROT_WIDTH-1:0])
                  + $signed({{(ROT_WIDTH-DIM_WIDTH){1'b0}}, half_cols});
   assign row_rot = $signed(row_shift[ROT_WIDTH-1:0])
                  + $signed({{(ROT_WIDTH-DIM_WIDTH){1'b0}}, half_rows});

   // keep the bayer phase of the output position
   assign col_src = {col_rot[ROT_WIDTH-1:1], dec.col[0]};
   assign row_src = {row_rot[ROT_WIDTH-1:1], dec.row[0]};

   // outside 0..dim-1 reads as zero later
   assign oob = col_src[ROT_WIDTH-1] || row_src[ROT_WIDTH-1]
             || (col_src >= $signed({{(ROT_WIDTH-DIM_WIDTH){1'b0}}, dec.num_cols}))
             || (row_src >= $signed({{(ROT_WIDTH-DIM_WIDTH){1'b0}}, dec.num_rows}));

   // row major address, kept wide to see overflow
   assign raddr_full = row_src[DIM_WIDTH-1:0] * dec.num_cols + col_src[DIM_WIDTH-1:0];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         fet.valid         <= 1'b0;
         fet.token         <= '0;
         fet.bank          <= 1'b0;
         fet.wr_addr       <= '0;
         fet.wr_en         <= 1'b0;
         fet.raddr         <= '0;
         fet.out_of_bounds <= 1'b0;
         fet.enable        <= 1'b0;
      end else begin
         fet.valid         <= dec.valid;
         fet.token         <= dec.token;
         fet.bank          <= dec.bank;
         fet.wr_addr       <= dec.wr_addr;
         fet.wr_en         <= dec.wr_en;
         fet.raddr         <= raddr_full[ADDR_WIDTH-1:0];
         fet.out_of_bounds <= oob;
         fet.enable        <= dec.enable;
      end
   end

   // a truncated read address is never used for a real fetch
   assert property (@(posedge clk) disable iff (!resetb)
      (dec.valid && (raddr_full > BANK_WORDS - 1)) |=> fet.out_of_bounds);

endmodule

`default_nettype wire

//--- rotator/pingpong_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module pingpong_buffer (
   input  logic                              clk,
   input  logic                              resetb,
   fetch_if.dst                              fet,
   output logic                              out_valid,
   output rotate_pkg::stream_dtype_e         out_dtype,
   output logic [rotate_pkg::DATA_WIDTH-1:0] out_data
);
   import rotate_pkg::*;

   // two banks, one filling while the other is read
   logic [DATA_WIDTH-1:0] mem [2][BANK_WORDS];
   logic [DATA_WIDTH-1:0] rd_data;
   logic [DATA_WIDTH-1:0] pass_data;
   logic                  rd_en;
   logic                  use_mem;
   logic                  oob_q;

   // only enabled pixels fetch from the previous frame
   assign rd_en = fet.valid && fet.enable && (fet.token.dtype == PIXEL);

   always_ff @(posedge clk) begin
      if (fet.wr_en) begin
         mem[fet.bank][fet.wr_addr] <= fet.token.data;
      end
      // read side is the bank finished last frame
      if (rd_en) begin
         rd_data <= mem[!fet.bank][fet.raddr];
      end
      // bypass path for markers and disabled mode
      pass_data <= fet.token.data;
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         out_valid <= 1'b0;
         out_dtype <= stream_dtype_e'(0);
         use_mem   <= 1'b0;
         oob_q     <= 1'b0;
      end else begin
         out_valid <= fet.valid;
         out_dtype <= fet.token.dtype;
         use_mem   <= rd_en;
         oob_q     <= fet.out_of_bounds;
      end
   end

   // zero for sources outside the image
   assign out_data = !use_mem ? pass_data : (oob_q ? '0 : rd_data);

   // after the last word of a bank, the next write waits for a new frame
   assert property (@(posedge clk) disable iff (!resetb)
      (fet.wr_en && (fet.wr_addr == ADDR_WIDTH'(BANK_WORDS - 1)))
      |=> (!fet.wr_en until (fet.valid && fet.token.dtype == FRAME_START)));

endmodule

`default_nettype wire

//--- hdl/image_rotator.sv
`timescale 1ns/100ps
`default_nettype none

module image_rotator (
   input  logic                                  clk,
   input  logic                                  resetb,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [rotate_pkg::APB_ADDR_WIDTH-1:0] paddr,
   input  logic [rotate_pkg::APB_DATA_WIDTH-1:0] pwdata,
   output logic [rotate_pkg::APB_DATA_WIDTH-1:0] prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   input  logic                                  in_valid,
   input  rotate_pkg::stream_dtype_e             in_dtype,
   input  logic [rotate_pkg::DATA_WIDTH-1:0]     in_data,
   output logic                                  out_valid,
   output rotate_pkg::stream_dtype_e             out_dtype,
   output logic [rotate_pkg::DATA_WIDTH-1:0]     out_data
);
   import rotate_pkg::*;

   logic                          enable;
   logic signed [ANGLE_WIDTH-1:0] sin_theta;
   logic signed [ANGLE_WIDTH-1:0] cos_theta;
   logic [DIM_WIDTH-1:0]          num_cols;
   logic [DIM_WIDTH-1:0]          num_rows;
   logic                          bank;

   // decode -> execute -> result
   decode_if dec_bus ();
   fetch_if  fet_bus ();

   rotate_apb_regs rotate_apb_regs_inst (
      .clk, .resetb, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr,
      .enable, .sin_theta, .cos_theta, .num_cols, .num_rows, .bank
   );

   stream_decode stream_decode_inst (
      .clk, .resetb, .in_valid, .in_dtype, .in_data,
      .enable, .sin_theta, .cos_theta, .num_cols, .num_rows, .bank,
      .dec (dec_bus.src)
   );

   coord_rotate coord_rotate_inst (
      .clk, .resetb, .dec (dec_bus.dst), .fet (fet_bus.src)
   );

   pingpong_buffer pingpong_buffer_inst (
      .clk, .resetb, .fet (fet_bus.dst), .out_valid, .out_dtype, .out_data
   );

endmodule

`default_nettype wire

//--- tests/tb_image_rotator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_image_rotator;
   import rotate_pkg::*;

   localparam int WAIT_LIMIT = 400;

   logic                      clk;
   logic                      resetb;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [APB_ADDR_WIDTH-1:0] paddr;
   logic [APB_DATA_WIDTH-1:0] pwdata;
   logic [APB_DATA_WIDTH-1:0] prdata;
   logic                      pready;
   logic                      pslverr;
   logic                      in_valid;
   stream_dtype_e             in_dtype;
   logic [DATA_WIDTH-1:0]     in_data;
   logic                      out_valid;
   stream_dtype_e             out_dtype;
   logic [DATA_WIDTH-1:0]     out_data;

   // reference model state mirroring registers, decode counters and both banks
   logic [DATA_WIDTH-1:0] m_mem [2][BANK_WORDS];
   bit  m_written [2][BANK_WORDS];
   bit  m_enable = 1'b0;
   bit  m_bank = 1'b0;
   int  m_sin = 0;
   int  m_cos = ANGLE_ONE;
   int  m_sin_q = 0;
   int  m_cos_q = ANGLE_ONE;
   int  m_row = 0;
   int  m_col = 0;
   int  m_wptr = 0;
   int  m_cols = DEFAULT_COLS;
   int  m_rows = DEFAULT_ROWS;

   // expected outputs queued three deep with one entry per clock
   logic          exp_valid_q [$];
   stream_token_t exp_tok_q [$];
   bit            exp_known_q [$];
   int            sent_valid = 0;
   int            checked_valid = 0;
   int            rot_checks = 0;
   bit            monitor_on = 1'b0;
   int unsigned   seed = 34;

   image_rotator image_rotator_inst (
      .clk, .resetb, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr,
      .in_valid, .in_dtype, .in_data, .out_valid, .out_dtype, .out_data
   );

   always #5 clk = ~clk;

   // lcg step returning the better upper bits
   function automatic int unsigned next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 16;
   endfunction

   task automatic stop_with_failure();
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("FAIL %0t ns %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      stop_with_failure();
   endtask

   task automatic check_token(input logic exp_valid, input logic act_valid,
                              input stream_token_t exp, input stream_token_t act,
                              input bit known);
      if (act_valid !== exp_valid)
         report_mismatch("out_valid", exp_valid, act_valid);
      if (act.dtype !== exp.dtype)
         report_mismatch("out_dtype", exp.dtype, act.dtype);
      // skipped where the model read a word never written
      if (known && act.data !== exp.data)
         report_mismatch("out_data", exp.data, act.data);
   endtask

   task automatic check_status(input string name, input logic [APB_DATA_WIDTH-1:0] exp,
                               input logic [APB_DATA_WIDTH-1:0] act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   // status as the model sees it
   function automatic logic [APB_DATA_WIDTH-1:0] status_word();
      logic [APB_DATA_WIDTH-1:0] w;
      w = '0;
      w[STAT_COLS_LSB +: DIM_WIDTH] = DIM_WIDTH'(m_cols);
      w[STAT_ROWS_LSB +: DIM_WIDTH] = DIM_WIDTH'(m_rows);
      w[STAT_BANK_BIT] = m_bank;
      return w;
   endfunction

   // one token through the decode rules and what should come out 3 cycles on
   task automatic model_step(input logic v, input stream_dtype_e dt,
                             input logic [DATA_WIDTH-1:0] d);
      stream_token_t exp;
      bit            known;
      bit            oob;
      int            hc;
      int            hr;
      int            cc;
      int            rc;
      int            csrc;
      int            rsrc;
      int            raddr;
      exp.dtype = dt;
      exp.data = d;
      known = 1'b1;
      if (v && m_enable) begin
         case (dt)
            FRAME_START: begin
               m_row = 0;
               m_col = 0;
               m_wptr = 0;
               m_bank = !m_bank;
               m_sin_q = m_sin;
               m_cos_q = m_cos;
            end
            ROW_START: m_col = 0;
            PIXEL: begin
               hc = m_cols / 2;
               hr = m_rows / 2;
               cc = m_col - hc;
               rc = m_row - hr;
               // signed int shift floors like the fixed point datapath
               csrc = ((cc * m_cos_q - rc * m_sin_q) >>> ANGLE_FRAC) + hc;
               rsrc = ((cc * m_sin_q + rc * m_cos_q) >>> ANGLE_FRAC) + hr;
               // bayer phase comes from the output position
               csrc = (csrc & ~1) | (m_col & 1);
               rsrc = (rsrc & ~1) | (m_row & 1);
               oob = csrc < 0 || rsrc < 0 || csrc >= m_cols || rsrc >= m_rows;
               if (oob) begin
                  exp.data = '0;
               end else begin
                  raddr = rsrc * m_cols + csrc;
                  known = m_written[!m_bank][raddr];
                  exp.data = m_mem[!m_bank][raddr];
                  rot_checks += known;
               end
               m_mem[m_bank][m_wptr] = d;
               m_written[m_bank][m_wptr] = 1'b1;
               m_col++;
               m_wptr = (m_wptr + 1) % BANK_WORDS;
            end
            ROW_END: begin
               m_row++;
               m_cols = m_col;
            end
            FRAME_END: m_rows = m_row;
            default: ;
         endcase
      end
      exp_valid_q.push_back(v);
      exp_tok_q.push_back(exp);
      exp_known_q.push_back(known);
      if (v)
         sent_valid++;
   endtask

   task automatic compare_oldest();
      logic          v;
      bit            known;
      stream_token_t exp;
      stream_token_t act;
      v = exp_valid_q.pop_front();
      exp = exp_tok_q.pop_front();
      known = exp_known_q.pop_front();
      act.dtype = out_dtype;
      act.data = out_data;
      if (v)
         checked_valid++;
      check_token(v, out_valid, exp, act, known);
   endtask

   // inputs and outputs are both settled at the falling edge
   always @(negedge clk) begin
      if (monitor_on) begin
         model_step(in_valid, in_dtype, in_data);
         if (exp_tok_q.size() > 3)
            compare_oldest();
      end
   end

   // stream is idle while the bus is busy
   task automatic apb_transfer(input bit write, input logic [APB_ADDR_WIDTH-1:0] addr,
                               input logic [APB_DATA_WIDTH-1:0] wdata,
                               output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
      int waited;
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= write;
      paddr <= addr;
      pwdata <= wdata;
      in_valid <= 1'b0;
      @(posedge clk);
      penable <= 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("timeout, pready never came up for address 0x%0h", addr);
            stop_with_failure();
         end
      end while (pready !== 1'b1);
      rdata = prdata;
      err = pslverr;
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] data, input bit exp_err);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_transfer(1'b1, addr, data, rd, err);
      check_status("pslverr", exp_err, err);
      // model registers change on the access edge just as the DUT's do
      if (!err) begin
         case (addr)
            REG_CTRL: m_enable = data[0];
            REG_SIN:  m_sin = $signed(data[ANGLE_WIDTH-1:0]);
            REG_COS:  m_cos = $signed(data[ANGLE_WIDTH-1:0]);
            default:  ;
         endcase
      end
   endtask

   task automatic read_reg(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [APB_DATA_WIDTH-1:0] exp, input bit exp_err);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_transfer(1'b0, addr, '0, rd, err);
      check_status("pslverr", exp_err, err);
      if (!exp_err)
         check_status(name, exp, rd);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   // one token with random data and a random gap of 0..2 cycles
   task automatic send_token(input stream_dtype_e dt);
      @(posedge clk);
      in_valid <= 1'b1;
      in_dtype <= dt;
      in_data <= DATA_WIDTH'(next_rand());
      idle_cycles(next_rand() % 3);
   endtask

   task automatic send_rows(input int rows, input int cols);
      for (int r = 0; r < rows; r++) begin
         send_token(ROW_START);
         for (int c = 0; c < cols; c++)
            send_token(PIXEL);
         send_token(ROW_END);
      end
   endtask

   // let the model catch up before reading learned size and bank
   task automatic compare_model_status();
      idle_cycles(2);
      read_reg("status", REG_STATUS, status_word(), 1'b0);
   endtask

   task automatic send_frame(input int rows, input int cols);
      send_token(FRAME_START);
      send_rows(rows, cols);
      send_token(FRAME_END);
      compare_model_status();
   endtask

   initial begin
      int s;
      int c;
      int waited;
      clk = 1'b0;
      resetb = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      in_valid = 1'b0;
      in_dtype = stream_dtype_e'(0);
      in_data = '0;
      repeat (16) @(posedge clk);
      resetb <= 1'b1;
      monitor_on = 1'b1;

      // defaults of 16x16 and bank 0
      read_reg("status", REG_STATUS, 32'h0000_1010, 1'b0);
      write_reg(REG_SIN, 32'hFFFF_FFB3, 1'b0);
      read_reg("sin", REG_SIN, 32'hFFFF_FFB3, 1'b0);
      write_reg(REG_COS, 32'd181, 1'b0);
      read_reg("cos", REG_COS, 32'd181, 1'b0);
      write_reg(REG_CTRL, 32'd1, 1'b0);
      read_reg("ctrl", REG_CTRL, 32'd1, 1'b0);
      write_reg(REG_CTRL, 32'd0, 1'b0);
      read_reg("ctrl", REG_CTRL, 32'd0, 1'b0);
      read_reg("unmapped", 4'h2, '0, 1'b1);
      write_reg(4'h6, 32'd5, 1'b1);
      write_reg(REG_STATUS, 32'd0, 1'b1);

      // bypass with any code and any gap
      repeat (80) begin
         @(posedge clk);
         in_valid <= next_rand() % 2;
         in_dtype <= stream_dtype_e'(3'(next_rand()));
         in_data <= DATA_WIDTH'(next_rand());
      end
      idle_cycles(4);

      // identity rotation where the second frame reads the first back
      write_reg(REG_SIN, 32'd0, 1'b0);
      write_reg(REG_COS, 32'd256, 1'b0);
      write_reg(REG_CTRL, 32'd1, 1'b0);
      send_frame(8, 8);
      read_reg("status", REG_STATUS, 32'h0001_0808, 1'b0);
      send_frame(8, 8);

      // quarter turn
      write_reg(REG_SIN, 32'd256, 1'b0);
      write_reg(REG_COS, 32'd0, 1'b0);
      send_frame(8, 8);

      // random angle on a wide frame
      s = int'(next_rand() % 513) - 256;
      c = int'(next_rand() % 513) - 256;
      write_reg(REG_SIN, s, 1'b0);
      write_reg(REG_COS, c, 1'b0);
      send_frame(6, 10);

      // new angle mid frame is held off until the next frame start
      send_token(FRAME_START);
      send_rows(3, 10);
      s = int'(next_rand() % 513) - 256;
      c = int'(next_rand() % 513) - 256;
      write_reg(REG_SIN, s, 1'b0);
      write_reg(REG_COS, c, 1'b0);
      send_rows(3, 10);
      send_token(FRAME_END);
      compare_model_status();
      send_frame(6, 10);

      idle_cycles(2);
      waited = 0;
      while (checked_valid != sent_valid) begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("timeout, tokens still missing at the output");
            stop_with_failure();
         end
      end
      if (rot_checks == 0) begin
         $display("no rotated pixel was ever compared");
         stop_with_failure();
      end

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
common/rotate_pkg.sv
common/decode_if.sv
common/fetch_if.sv
hdl/rotate_apb_regs.sv
rotator/stream_decode.sv
rotator/coord_rotate.sv
rotator/pingpong_buffer.sv
hdl/image_rotator.sv
tests/tb_image_rotator.sv

//--- Bender.yml
package:
  name: image_rotator

sources:
  - common/rotate_pkg.sv
  - common/decode_if.sv
  - common/fetch_if.sv
  - hdl/rotate_apb_regs.sv
  - rotator/stream_decode.sv
  - rotator/coord_rotate.sv
  - rotator/pingpong_buffer.sv
  - hdl/image_rotator.sv
  - target: test
    files:
      - tests/tb_image_rotator.sv
